// File: ckpt_pkg.sv
package ckpt_pkg;

    // selects one of up to 4 checkpoint pages
    typedef logic [1:0] ckpt_id_t;

    // one bit wider than the tag, so full and empty differ
    typedef logic [7:0] fl_ptr_t;

    typedef logic [7:0] rq_ptr_t;

    typedef struct packed {
        logic     save;     // store state into page
        logic     restore;  // reload state from page
        ckpt_id_t page;
    } ckpt_cmd_t;

endpackage

// File: free_list.sv
module free_list #(
    parameter int NUM_ARCH = 32,
    parameter int NUM_PHYS = 64,
    parameter int NUM_CKPT = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        alloc,
    output rename_types_pkg::phys_tag_t free_tag,
    output logic                        empty,
    input  logic                        release_en,
    input  rename_types_pkg::phys_tag_t release_tag,
    input  ckpt_pkg::ckpt_cmd_t         ckpt
);
    import rename_types_pkg::*;
    import ckpt_pkg::*;

    // tags not held by the map at reset
    localparam int DEPTH = NUM_PHYS - NUM_ARCH;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // ring rounded up to a power of two so the pointers wrap on their own
    localparam int SLOTS = 2 ** IDX_W;

    typedef logic [IDX_W-1:0] slot_idx_t;

    phys_tag_t tags [SLOTS];
    fl_ptr_t   rd_ptr;
    fl_ptr_t   wr_ptr;
    fl_ptr_t   saved_rd [NUM_CKPT];  // one read pointer per page
    slot_idx_t rd_idx;
    slot_idx_t wr_idx;

    assign rd_idx = rd_ptr[IDX_W-1:0];
    assign wr_idx = wr_ptr[IDX_W-1:0];

    // head of the list goes straight to the map
    assign free_tag = tags[rd_idx];
    assign empty    = (rd_ptr == wr_ptr);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SLOTS; i++) begin
                tags[i] <= phys_tag_t'(NUM_ARCH + i);  // tail slots beyond DEPTH unused
            end
        end else if (release_en) begin
            tags[wr_idx] <= release_tag;  // committed tag joins the tail
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= fl_ptr_t'(DEPTH);  // list starts full
        end else begin
            if (release_en) begin
                wr_ptr <= wr_ptr + fl_ptr_t'(1);
            end
            // rewinding the read pointer hands back every tag given out since the save
            if (ckpt.restore) begin
                rd_ptr <= saved_rd[ckpt.page];
            end else if (alloc && !empty) begin
                rd_ptr <= rd_ptr + fl_ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < NUM_CKPT; p++) begin
                saved_rd[p] <= '0;  // same as the reset read pointer
            end
        end else if (ckpt.save) begin
            saved_rd[ckpt.page] <= rd_ptr;  // no alloc can share this cycle
        end
    end

endmodule

// File: list.f
rename_types_pkg.sv
ckpt_pkg.sv
free_list.sv
rename_map.sv
retire_queue.sv
rename_top.sv
rename_sva.sv
rename_tb.sv

// File: rename_input.txt
// columns: op, arg (arch reg / page / stall value), expected new tag, expected old tag, run length
// ops: 00 idle, 01 rename, 02 commit, 03 save, 04 restore, 05 expect stall,
//      06 rename while stalled, 07 run of renames on one register, ff end
0000000000
0500000000
0101200100
0102210200
0103220300
0101232000
0200000000
0200000000
0301000000
0104240400
0101252300
0105260500
0401000000
0101242300
0104250400
070626061a
0107010700
0108020800
0501000000
0609000000
0501000000
0200000000
0500000000
0109030900
0501000000
ff00000000

// File: rename_map.sv
module rename_map #(
    parameter int NUM_ARCH = 32,
    parameter int NUM_CKPT = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  rename_types_pkg::rename_req_t rename_req,
    output rename_types_pkg::rename_rsp_t rename_rsp,
    input  rename_types_pkg::phys_tag_t   free_tag,
    input  logic                          empty,
    output logic                          alloc,
    output logic                          push,
    output rename_types_pkg::phys_tag_t   push_tag,
    input  ckpt_pkg::ckpt_cmd_t           ckpt
);
    import rename_types_pkg::*;

    phys_tag_t map [NUM_ARCH];
    phys_tag_t ckpt_map [NUM_CKPT][NUM_ARCH];  // full map copy per page

    logic      fire;
    phys_tag_t cur_tag;
    logic      done_q;
    phys_tag_t new_tag_q;
    phys_tag_t old_tag_q;

    // a request is dropped while the free list is dry
    assign fire    = rename_req.valid && !empty;
    assign cur_tag = map[rename_req.dest];

    assign alloc    = fire;
    assign push     = fire;
    assign push_tag = cur_tag;  // displaced mapping waits in the retire queue

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                map[i] <= phys_tag_t'(i);  // identity mapping
            end
        end else if (ckpt.restore) begin
            map <= ckpt_map[ckpt.page];
        end else if (fire) begin
            map[rename_req.dest] <= free_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < NUM_CKPT; p++) begin
                for (int i = 0; i < NUM_ARCH; i++) begin
                    ckpt_map[p][i] <= phys_tag_t'(i);
                end
            end
        end else if (ckpt.save) begin
            ckpt_map[ckpt.page] <= map;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= fire;
        end
    end

    // response payload, only meaningful with done
    always_ff @(posedge clk) begin
        if (fire) begin
            new_tag_q <= free_tag;
            old_tag_q <= cur_tag;  // value before this cycle's write
        end
    end

    assign rename_rsp = '{done: done_q, new_tag: new_tag_q, old_tag: old_tag_q};

endmodule

// File: rename_sva.sv
module rename_sva (
    input logic                          clk,
    input logic                          reset,
    input rename_types_pkg::rename_req_t rename_req,
    input rename_types_pkg::rename_rsp_t rename_rsp,
    input ckpt_pkg::ckpt_cmd_t           ckpt,
    input logic                          stall
);

    // a restore rewinds every pointer, so a rename in that cycle would be lost
    no_rename_on_restore: assert property (
        @(posedge clk) disable iff (reset)
        !(rename_req.valid && ckpt.restore)
    ) else $error("rename issued in the same cycle as a checkpoint restore");

    no_save_on_rename: assert property (
        @(posedge clk) disable iff (reset)
        !(ckpt.save && rename_req.valid)
    ) else $error("checkpoint save issued in the same cycle as a rename");

    // stalled requests are dropped by the map
    no_done_after_stall: assert property (
        @(posedge clk) disable iff (reset)
        (rename_req.valid && stall) |=> !rename_rsp.done
    ) else $error("rename response raised for a request made while stalled");

endmodule

// File: rename_tb.sv
module rename_tb;
    import rename_types_pkg::*;
    import ckpt_pkg::*;

    localparam int MAX_OPS    = 64;
    localparam int RESET_CYC  = 16;
    localparam int CLK_PERIOD = 4;

    // one line of rename_input.txt
    typedef struct packed {
        logic [7:0] op;
        logic [7:0] arg;      // arch reg, page or stall value
        logic [7:0] new_tag;
        logic [7:0] old_tag;
        logic [7:0] count;    // run length, op 07 only
    } op_line_t;

    logic        clk = 1'b0;
    logic        reset;
    rename_req_t rename_req;
    rename_rsp_t rename_rsp;
    logic        commit;
    ckpt_cmd_t   ckpt;
    logic        stall;

    logic [39:0] ops [MAX_OPS];
    int          watchdog_limit = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rename_top rename_top_inst (
        .clk        (clk),
        .reset      (reset),
        .rename_req (rename_req),
        .rename_rsp (rename_rsp),
        .commit     (commit),
        .ckpt       (ckpt),
        .stall      (stall)
    );

    bind rename_top rename_sva rename_sva_inst (
        .clk        (clk),
        .reset      (reset),
        .rename_req (rename_req),
        .rename_rsp (rename_rsp),
        .ckpt       (ckpt),
        .stall      (stall)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_tag(input string name, input phys_tag_t actual,
                             input phys_tag_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR time %0t: %s is %0d, expected %0d",
                                $time, name, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR time %0t: %s is %b, expected %b",
                                $time, name, actual, expected));
        end
    endtask

    // inputs change 1 unit after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic rename_one(input arch_reg_t dest, input phys_tag_t exp_new,
                              input phys_tag_t exp_old);
        rename_req = '{valid: 1'b1, dest: dest};
        next_cycle();
        rename_req = '0;
        check_flag("rename_rsp.done", rename_rsp.done, 1'b1);
        check_tag("rename_rsp.new_tag", rename_rsp.new_tag, exp_new);
        check_tag("rename_rsp.old_tag", rename_rsp.old_tag, exp_old);
    endtask

    // same register every cycle, so each rename displaces the one before
    task automatic run_renames(input arch_reg_t dest, input phys_tag_t first_new,
                               input phys_tag_t first_old, input int count);
        phys_tag_t exp_old;
        exp_old = first_old;
        for (int i = 0; i < count; i++) begin
            rename_one(dest, phys_tag_t'(int'(first_new) + i), exp_old);
            exp_old = phys_tag_t'(int'(first_new) + i);
        end
    endtask

    task automatic rename_stalled(input arch_reg_t dest);
        rename_req = '{valid: 1'b1, dest: dest};
        next_cycle();
        rename_req = '0;
        check_flag("rename_rsp.done", rename_rsp.done, 1'b0);
    endtask

    task automatic pulse_commit();
        commit = 1'b1;
        next_cycle();
        commit = 1'b0;
    endtask

    task automatic pulse_ckpt(input logic is_save, input ckpt_id_t page);
        ckpt = '{save: is_save, restore: !is_save, page: page};
        next_cycle();
        ckpt = '0;
    endtask

    initial begin : watchdog
        wait (watchdog_limit > 0);
        #(watchdog_limit);
        abort_run("watchdog expired, the operation stream never finished");
    end

    initial begin : main
        op_line_t line;
        logic     found_end;
        int       num_ops;
        int       cycles;
        reset      = 1'b1;
        rename_req = '0;
        commit     = 1'b0;
        ckpt       = '0;
        found_end  = 1'b0;
        num_ops    = 0;
        cycles     = 0;
        $readmemh("rename_input.txt", ops);
        for (int k = 0; k < MAX_OPS; k++) begin
            line = op_line_t'(ops[k]);
            if (!found_end) begin
                if (line.op == 8'hff) begin
                    found_end = 1'b1;
                    num_ops   = k;
                end else begin
                    cycles += (line.op == 8'h07) ? int'(line.count) : 1;
                end
            end
        end
        if (!found_end) begin
            abort_run("rename_input.txt has no end line");
        end else begin
            watchdog_limit = 4 * cycles * CLK_PERIOD + RESET_CYC * CLK_PERIOD;
            repeat (RESET_CYC) @(posedge clk);
            #1;
            reset = 1'b0;
            for (int k = 0; k < num_ops; k++) begin
                line = op_line_t'(ops[k]);
                case (line.op)
                    8'h00: begin
                        next_cycle();
                        check_flag("rename_rsp.done", rename_rsp.done, 1'b0);
                    end
                    8'h01: rename_one(line.arg[4:0], line.new_tag[6:0], line.old_tag[6:0]);
                    8'h02: pulse_commit();
                    8'h03: pulse_ckpt(1'b1, line.arg[1:0]);
                    8'h04: pulse_ckpt(1'b0, line.arg[1:0]);
                    8'h05: check_flag("stall", stall, line.arg[0]);
                    8'h06: rename_stalled(line.arg[4:0]);
                    8'h07: run_renames(line.arg[4:0], line.new_tag[6:0], line.old_tag[6:0],
                                       int'(line.count));
                    default: abort_run($sformatf("unknown operation %0h on data line %0d",
                                                 line.op, k));
                endcase
            end
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: rename_top.sv
module rename_top #(
    parameter int NUM_ARCH = 32,
    parameter int NUM_PHYS = 64,   // at most 128
    parameter int NUM_CKPT = 4     // at most 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  rename_types_pkg::rename_req_t rename_req,
    output rename_types_pkg::rename_rsp_t rename_rsp,
    input  logic                          commit,
    input  ckpt_pkg::ckpt_cmd_t           ckpt,
    output logic                          stall
);
    import rename_types_pkg::*;

    phys_tag_t free_tag;
    phys_tag_t push_tag;
    phys_tag_t release_tag;
    logic      empty;
    logic      alloc;
    logic      push;
    logic      release_en;

    // back-pressure is just the free list running dry
    assign stall = empty;

    free_list #(
        .NUM_ARCH (NUM_ARCH),
        .NUM_PHYS (NUM_PHYS),
        .NUM_CKPT (NUM_CKPT)
    ) free_list_inst (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc),
        .free_tag    (free_tag),
        .empty       (empty),
        .release_en  (release_en),
        .release_tag (release_tag),
        .ckpt        (ckpt)
    );

    rename_map #(
        .NUM_ARCH (NUM_ARCH),
        .NUM_CKPT (NUM_CKPT)
    ) rename_map_inst (
        .clk        (clk),
        .reset      (reset),
        .rename_req (rename_req),
        .rename_rsp (rename_rsp),
        .free_tag   (free_tag),
        .empty      (empty),
        .alloc      (alloc),
        .push       (push),
        .push_tag   (push_tag),
        .ckpt       (ckpt)
    );

    retire_queue #(
        .NUM_PHYS (NUM_PHYS),
        .NUM_CKPT (NUM_CKPT)
    ) retire_queue_inst (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .push_tag    (push_tag),
        .commit      (commit),
        .release_en  (release_en),
        .release_tag (release_tag),
        .ckpt        (ckpt)
    );

endmodule

// File: rename_types_pkg.sv
package rename_types_pkg;

    // up to 128 physical registers
    typedef logic [6:0] phys_tag_t;

    // 32 architectural registers
    typedef logic [4:0] arch_reg_t;

    typedef struct packed {
        logic      valid;  // rename strobe
        arch_reg_t dest;   // destination arch register
    } rename_req_t;

    typedef struct packed {
        logic      done;     // one cycle after an accepted rename
        phys_tag_t new_tag;  // tag handed out by the free list
        phys_tag_t old_tag;  // mapping displaced by this rename
    } rename_rsp_t;

endpackage

// File: retire_queue.sv
module retire_queue #(
    parameter int NUM_PHYS = 64,
    parameter int NUM_CKPT = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        push,
    input  rename_types_pkg::phys_tag_t push_tag,
    input  logic                        commit,
    output logic                        release_en,
    output rename_types_pkg::phys_tag_t release_tag,
    input  ckpt_pkg::ckpt_cmd_t         ckpt
);
    import rename_types_pkg::*;
    import ckpt_pkg::*;

    // never more outstanding tags than physical registers
    localparam int IDX_W = $clog2(NUM_PHYS);
    localparam int SLOTS = 2 ** IDX_W;

    phys_tag_t slots [SLOTS];
    rq_ptr_t   rd_ptr;
    rq_ptr_t   wr_ptr;
    rq_ptr_t   saved_wr [NUM_CKPT];
    logic      q_empty;

    assign q_empty     = (rd_ptr == wr_ptr);
    assign release_en  = commit && !q_empty;  // commit on empty queue is dropped
    assign release_tag = slots[rd_ptr[IDX_W-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr[IDX_W-1:0]] <= push_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            // squashed renames vanish when the tail moves back
            if (ckpt.restore) begin
                wr_ptr <= saved_wr[ckpt.page];
            end else if (push) begin
                wr_ptr <= wr_ptr + rq_ptr_t'(1);
            end
            if (release_en) begin
                rd_ptr <= rd_ptr + rq_ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < NUM_CKPT; p++) begin
                saved_wr[p] <= '0;
            end
        end else if (ckpt.save) begin
            saved_wr[ckpt.page] <= wr_ptr;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the rename testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module rename_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vrename_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
